/* src.f */
+incdir+verilog
+incdir+tb
verilog/pix_reg_pkg.sv
verilog/spi_edge_sync.sv
verilog/ctrl_regs.sv
verilog/group_commit.sv
verilog/status_snapshot.sv
verilog/rd_mux.sv
verilog/pix_reg_bank.sv
tb/tb_pix_reg_bank.sv

/* Makefile */
# Verilator build and run of the register bank testbench

TOP = tb_pix_reg_bank

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

/* tb/tb_bus_tasks.svh */
// testbench helpers for the register bank
// galois lfsr random bits, value check with error count
// bus write, bus read, read-command pulse, pulse watch with timeout

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH
`default_nettype none

// one galois step with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
endfunction

// n random bits into the low end with one lfsr step per bit
task automatic rand_bits(input int n, output logic [15:0] v);
	int k;
	v = '0;
	for (k = 0; k < n; k++) begin
		v          = {v[14:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	assert (act === exp) else begin
		$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		errors++;
	end
endtask

// enable high 5 cycles then low 3 so the strobe lands in the middle
task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
	@(posedge clk_pix);
	i_addr    <= addr;
	i_wr_data <= data;
	i_wr_en   <= 1'b1;
	repeat (5) @(posedge clk_pix);
	i_wr_en <= 1'b0;
	repeat (3) @(posedge clk_pix);
endtask

task automatic check_read(input logic [15:0] addr, input logic en, input logic exp_sel,
	input logic [15:0] exp_data);
	@(posedge clk_pix);
	i_addr  <= addr;
	i_rd_en <= en;
	@(posedge clk_pix);
	@(negedge clk_pix);     // comb read path settled
	check_val($sformatf("o_pix_sel at %h", addr), exp_sel, o_pix_sel);
	check_val($sformatf("o_pix_rd_data at %h", addr), exp_data, o_pix_rd_data);
	@(posedge clk_pix);
	i_rd_en <= 1'b0;
endtask

task automatic pulse_read_cmd();
	@(posedge clk_pix);
	i_cmd_is_rd <= 1'b1;
	repeat (5) @(posedge clk_pix);
	i_cmd_is_rd <= 1'b0;
	repeat (3) @(posedge clk_pix);
endtask

function automatic logic [1:0] pulse_field(input int which);
	case (which)
		0       : pulse_field = {1'b0, o_ctrl.cfg_done};
		1       : pulse_field = {1'b0, o_ctrl.trig_soft};
		default : pulse_field = o_ctrl.int_clr;
	endcase
endfunction

// pulse due at the third edge after the enable is first sampled
task automatic watch_pulse(input int which, input string name, input logic [1:0] exp);
	int waited;
	waited = 0;
	while (i_wr_en !== 1'b1 && waited < 20) begin
		@(negedge clk_pix);
		waited++;
	end
	if (i_wr_en !== 1'b1) begin
		$display("Timeout at %0t ns: write enable for %s not raised within 20 cycles",
			$time, name);
		timeouts++;
	end else begin
		repeat (3) @(negedge clk_pix);
		check_val(name, exp, pulse_field(which));
		repeat (8) begin
			@(negedge clk_pix);
			check_val(name, 32'h0, pulse_field(which));
		end
	end
endtask

`default_nettype wire
`endif

/* tb/tb_pix_reg_bank.sv */
// testbench of the pixel-clock register bank
// clock, reset, DUT, directed and random register checks
// closing line with check, error and timeout counts

`timescale 1ns/1ns
`include "pix_reg_settings.svh"
`default_nettype none

module tb_pix_reg_bank;
	import pix_reg_pkg::*;

	logic                    clk_pix;
	logic                    i_rst;
	logic                    i_wr_en;
	logic                    i_rd_en;
	logic                    i_cmd_is_rd;
	logic [`PIX_ADDR_W-1:0]  i_addr;
	logic [`PIX_SHORT_W-1:0] i_wr_data;
	status_in_t              i_status;
	logic                    o_pix_sel;
	logic [`PIX_SHORT_W-1:0] o_pix_rd_data;
	ctrl_cfg_t               o_ctrl;
	group_cfg_t              o_group;

	logic [31:0] lfsr_state = 32'h2a72_b16b;
	int          checks     = 0;
	int          errors     = 0;
	int          timeouts   = 0;

	// ----------------------------------------------------------------------
	// register tables
	logic [15:0] rw_addr [20] = '{`PIX_A_TEST, `PIX_A_SE, `PIX_A_ACQ, `PIX_A_TRIG_MODE,
		`PIX_A_TRIG_SRC, `PIX_A_TRIG_ACT, `PIX_A_USEROUT, `PIX_A_LINE2, `PIX_A_LINE3,
		`PIX_A_INT_EN, `PIX_A_FILT_RISE_H, `PIX_A_FILT_RISE_L, `PIX_A_FILT_FALL_H,
		`PIX_A_FILT_FALL_L, `PIX_A_DLY_H, `PIX_A_DLY_L, `PIX_A_PIXFMT_H, `PIX_A_PIXFMT_L,
		`PIX_A_PAYLOAD_3, `PIX_A_PAYLOAD_4};
	logic [15:0] rw_mask [20] = '{16'hffff, 16'h0001, 16'h0001, 16'h0001, 16'h000f, 16'h0001,
		16'h0007, 16'h001f, 16'h001f, 16'h0003, 16'h0007, 16'hffff, 16'h0007, 16'hffff,
		16'h0fff, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff};
	logic [15:0] zero_addr [19] = '{`PIX_A_CFG_DONE, `PIX_A_SE, `PIX_A_STATE, `PIX_A_ACQ,
		`PIX_A_PAYLOAD_1, `PIX_A_PAYLOAD_2, `PIX_A_TRIG_MODE, `PIX_A_TRIG_SOFT,
		`PIX_A_FILT_RISE_H, `PIX_A_FILT_RISE_L, `PIX_A_FILT_FALL_H, `PIX_A_FILT_FALL_L,
		`PIX_A_DLY_H, `PIX_A_DLY_L, `PIX_A_USEROUT, `PIX_A_LINE0, `PIX_A_LINE_STATUS,
		`PIX_A_INT_EN, `PIX_A_INT_CLR};
	// two-halves registers with the high half first
	logic [15:0] grp_addr [10] = '{`PIX_A_FILT_RISE_H, `PIX_A_FILT_RISE_L, `PIX_A_FILT_FALL_H,
		`PIX_A_FILT_FALL_L, `PIX_A_DLY_H, `PIX_A_DLY_L, `PIX_A_PIXFMT_H, `PIX_A_PIXFMT_L,
		`PIX_A_PAYLOAD_3, `PIX_A_PAYLOAD_4};
	int          grp_bits [10] = '{`PIX_FILT_H_W, 16, `PIX_FILT_H_W, 16, `PIX_DLY_H_W, 16,
		16, 16, 16, 16};
	logic [15:0] grp_val [10];

	pix_reg_bank uut (
		.clk_pix       (clk_pix),
		.i_rst         (i_rst),
		.i_wr_en       (i_wr_en),
		.i_rd_en       (i_rd_en),
		.i_cmd_is_rd   (i_cmd_is_rd),
		.i_addr        (i_addr),
		.i_wr_data     (i_wr_data),
		.i_status      (i_status),
		.o_pix_sel     (o_pix_sel),
		.o_pix_rd_data (o_pix_rd_data),
		.o_ctrl        (o_ctrl),
		.o_group       (o_group)
	);

	initial begin
		clk_pix = 1'b0;
		forever #50 clk_pix = ~clk_pix;     // 100 ns period
	end

	task automatic check_group(input logic [31:0] rise, input logic [31:0] fall,
		input logic [31:0] dly, input logic [31:0] fmt, input logic [31:0] pay);
		check_val("o_group.filt_rise", rise, o_group.filt_rise);
		check_val("o_group.filt_fall", fall, o_group.filt_fall);
		check_val("o_group.delay", dly, o_group.delay);
		check_val("o_group.pixfmt", fmt, o_group.pixfmt);
		check_val("o_group.payload", pay, o_group.payload);
	endtask

	initial begin
		logic [15:0] d;
		logic [15:0] exp_state;
		status_in_t  st;
		int          i;
		i_rst       = 1'b1;
		i_wr_en     = 1'b0;
		i_rd_en     = 1'b0;
		i_cmd_is_rd = 1'b0;
		i_addr      = '0;
		i_wr_data   = '0;
		i_status    = '0;
		repeat (4) @(posedge clk_pix);
		i_rst <= 1'b0;
		@(negedge clk_pix);

		// ----------------------------------------------------------------------
		// reset values on the outputs and the read port
		check_val("o_pix_sel", 32'h0, o_pix_sel);
		check_val("o_ctrl.cfg_done", 32'h0, o_ctrl.cfg_done);
		check_val("o_ctrl.trig_soft", 32'h0, o_ctrl.trig_soft);
		check_val("o_ctrl.int_clr", 32'h0, o_ctrl.int_clr);
		check_val("o_ctrl.test", `PIX_RST_TEST, o_ctrl.test);
		check_val("o_ctrl.stream_en", 32'h0, o_ctrl.stream_en);
		check_val("o_ctrl.acq_start", 32'h0, o_ctrl.acq_start);
		check_val("o_ctrl.trig_mode", 32'h0, o_ctrl.trig_mode);
		check_val("o_ctrl.trig_src", `PIX_RST_TRIG_SRC, o_ctrl.trig_src);
		check_val("o_ctrl.trig_act", `PIX_RST_TRIG_ACT, o_ctrl.trig_act);
		check_val("o_ctrl.user_out", 32'h0, o_ctrl.user_out);
		check_val("o_ctrl.int_en", 32'h0, o_ctrl.int_en);
		check_val("o_ctrl.line", {`PIX_RST_LINE3, `PIX_RST_LINE2, `PIX_RST_LINE1,
			`PIX_RST_LINE0}, o_ctrl.line);
		check_group(0, 0, 0, {`PIX_RST_PIXFMT_H, `PIX_RST_PIXFMT_L},
			{`PIX_RST_PAYLOAD_3, `PIX_RST_PAYLOAD_4});
		check_read(`PIX_A_TEST, 1'b1, 1'b1, `PIX_RST_TEST);
		check_read(`PIX_A_TRIG_SRC, 1'b1, 1'b1, `PIX_RST_TRIG_SRC);
		check_read(`PIX_A_TRIG_ACT, 1'b1, 1'b1, `PIX_RST_TRIG_ACT);
		check_read(`PIX_A_LINE1, 1'b1, 1'b1, `PIX_RST_LINE1);
		check_read(`PIX_A_LINE2, 1'b1, 1'b1, `PIX_RST_LINE2);
		check_read(`PIX_A_LINE3, 1'b1, 1'b1, `PIX_RST_LINE3);
		check_read(`PIX_A_PIXFMT_H, 1'b1, 1'b1, `PIX_RST_PIXFMT_H);
		check_read(`PIX_A_PIXFMT_L, 1'b1, 1'b1, `PIX_RST_PIXFMT_L);
		check_read(`PIX_A_PAYLOAD_3, 1'b1, 1'b1, `PIX_RST_PAYLOAD_3);
		check_read(`PIX_A_PAYLOAD_4, 1'b1, 1'b1, `PIX_RST_PAYLOAD_4);
		for (i = 0; i < 19; i++)
			check_read(zero_addr[i], 1'b1, 1'b1, 16'h0000);

		// ----------------------------------------------------------------------
		// read-write registers with random data and unmapped reads
		for (i = 0; i < 20; i++) begin
			rand_bits(16, d);
			bus_write(rw_addr[i], d);
			check_read(rw_addr[i], 1'b1, 1'b1, d & rw_mask[i]);
		end
		check_read(16'h0011, 1'b1, 1'b0, 16'h0000);
		check_read(16'h0200, 1'b1, 1'b0, 16'h0000);  // decodes as 0 which is unmapped
		check_read(`PIX_A_TEST, 1'b0, 1'b0, 16'h0000);   // rd_en low

		// line words with mode fixed on lines 0 and 1
		bus_write(`PIX_A_LINE0, 16'hffff);
		bus_write(`PIX_A_LINE1, 16'hffff);
		bus_write(`PIX_A_LINE2, 16'hffff);
		check_read(`PIX_A_LINE0, 1'b1, 1'b1, 16'h001e);  // stays input
		check_read(`PIX_A_LINE1, 1'b1, 1'b1, 16'h001f);  // stays output
		check_read(`PIX_A_LINE2, 1'b1, 1'b1, 16'h001f);
		check_val("o_ctrl.line[0].mode", 32'h0, o_ctrl.line[0].mode);
		check_val("o_ctrl.line[2]", 32'h1f, o_ctrl.line[2]);
		rand_bits(5, d);
		bus_write(`PIX_A_LINE3, d);
		check_val("o_ctrl.line[3].mode", d[0], o_ctrl.line[3].mode);
		check_val("o_ctrl.line[3].invert", d[1], o_ctrl.line[3].invert);
		check_val("o_ctrl.line[3].source", d[4:2], o_ctrl.line[3].source);

		// ----------------------------------------------------------------------
		// staged halves read back while o_group waits for config done
		for (i = 0; i < 10; i++) begin
			rand_bits(grp_bits[i], grp_val[i]);
			bus_write(grp_addr[i], grp_val[i]);
		end
		for (i = 0; i < 10; i++)
			check_read(grp_addr[i], 1'b1, 1'b1, grp_val[i]);
		check_group(0, 0, 0, {`PIX_RST_PIXFMT_H, `PIX_RST_PIXFMT_L},
			{`PIX_RST_PAYLOAD_3, `PIX_RST_PAYLOAD_4});
		fork
			bus_write(`PIX_A_CFG_DONE, 16'h0001);
			watch_pulse(0, "o_ctrl.cfg_done", 2'b01);
		join
		check_group({grp_val[0][2:0], grp_val[1]}, {grp_val[2][2:0], grp_val[3]},
			{grp_val[4][11:0], grp_val[5]}, {grp_val[6], grp_val[7]}, {grp_val[8], grp_val[9]});

		// self clearing pulses
		fork
			bus_write(`PIX_A_TRIG_SOFT, 16'h0001);
			watch_pulse(1, "o_ctrl.trig_soft", 2'b01);
		join
		fork
			bus_write(`PIX_A_INT_CLR, 16'h0003);
			watch_pulse(2, "o_ctrl.int_clr", 2'b11);
		join

		// ----------------------------------------------------------------------
		// status snapshot frozen until the next read command
		rand_bits(8, d);
		st = d[7:0];
		exp_state = {12'h000, st.sensor_rst_done, st.full_frame, st.ddr_error, st.ddr_init_done};
		@(posedge clk_pix);
		i_status <= st;
		repeat (5) @(posedge clk_pix);     // past the synchronizers
		pulse_read_cmd();
		check_read(`PIX_A_STATE, 1'b1, 1'b1, exp_state);
		check_read(`PIX_A_LINE_STATUS, 1'b1, 1'b1, st.line_status);
		@(posedge clk_pix);
		i_status <= ~st;
		repeat (5) @(posedge clk_pix);
		check_read(`PIX_A_STATE, 1'b1, 1'b1, exp_state);
		check_read(`PIX_A_LINE_STATUS, 1'b1, 1'b1, st.line_status);

		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// bus tasks, lfsr and checks
	`include "tb_bus_tasks.svh"

endmodule

`default_nettype wire

/* verilog/pix_reg_bank.sv */
// pixel-clock register bank top
// strobe recovery, control registers, group commit
// status snapshot and read multiplexer

`timescale 1ns/1ns
`include "pix_reg_settings.svh"
`default_nettype none

module pix_reg_bank (
	input  wire                      clk_pix,
	input  wire                      i_rst,
	input  wire                      i_wr_en,        // async to clk_pix
	input  wire                      i_rd_en,        // async, read path is combinational
	input  wire                      i_cmd_is_rd,    // async
	input  wire [`PIX_ADDR_W-1:0]    i_addr,
	input  wire [`PIX_SHORT_W-1:0]   i_wr_data,
	input  pix_reg_pkg::status_in_t  i_status,
	output logic                     o_pix_sel,
	output logic [`PIX_SHORT_W-1:0]  o_pix_rd_data,
	output pix_reg_pkg::ctrl_cfg_t   o_ctrl,
	output pix_reg_pkg::group_cfg_t  o_group
);
	import pix_reg_pkg::*;

	logic         wr_stb;     // one cycle per write
	logic         snap_stb;   // one cycle per read command
	logic         cfg_done;
	stage_cfg_t   stage;
	status_snap_t snap;

	spi_edge_sync u_edge_sync (
		.clk_pix     (clk_pix),
		.i_rst       (i_rst),
		.i_wr_en     (i_wr_en),
		.i_cmd_is_rd (i_cmd_is_rd),
		.o_wr_stb    (wr_stb),
		.o_snap_stb  (snap_stb)
	);

	ctrl_regs u_ctrl_regs (
		.clk_pix    (clk_pix),
		.i_rst      (i_rst),
		.i_wr_stb   (wr_stb),
		.i_addr     (i_addr),
		.i_wr_data  (i_wr_data),
		.o_ctrl     (o_ctrl),
		.o_stage    (stage),
		.o_cfg_done (cfg_done)
	);

	group_commit u_group_commit (
		.clk_pix    (clk_pix),
		.i_rst      (i_rst),
		.i_cfg_done (cfg_done),
		.i_stage    (stage),
		.o_group    (o_group)
	);

	status_snapshot u_status_snapshot (
		.clk_pix    (clk_pix),
		.i_rst      (i_rst),
		.i_snap_stb (snap_stb),
		.i_status   (i_status),
		.o_snap     (snap)
	);

	rd_mux u_rd_mux (
		.i_rd_en       (i_rd_en),
		.i_addr        (i_addr),
		.i_ctrl        (o_ctrl),
		.i_stage       (stage),
		.i_snap        (snap),
		.o_pix_sel     (o_pix_sel),
		.o_pix_rd_data (o_pix_rd_data)
	);

endmodule

`default_nettype wire

/* verilog/rd_mux.sv */
// read side of the register bank
// combinational decode of addr[8:0] into select flag and data
// grouped registers read back their staged halves

`timescale 1ns/1ns
`include "pix_reg_settings.svh"
`default_nettype none

module rd_mux (
	input  wire                        i_rd_en,
	input  wire [`PIX_ADDR_W-1:0]      i_addr,
	input  pix_reg_pkg::ctrl_cfg_t     i_ctrl,
	input  pix_reg_pkg::stage_cfg_t    i_stage,
	input  pix_reg_pkg::status_snap_t  i_snap,
	output logic                       o_pix_sel,      // this bank owns the address
	output logic [`PIX_SHORT_W-1:0]    o_pix_rd_data
);

	always_comb begin
		o_pix_sel     = 1'b0;
		o_pix_rd_data = '0;
		if (i_rd_en) begin
			o_pix_sel = 1'b1;   // dropped again for unmapped addresses
			case (i_addr[`PIX_DEC_W-1:0])
				// ----------------------------------------------------------------------
				// general
				`PIX_A_TEST      : o_pix_rd_data = i_ctrl.test;
				`PIX_A_CFG_DONE  : o_pix_rd_data = {{(`PIX_SHORT_W-1){1'b0}}, i_ctrl.cfg_done};
				`PIX_A_SE        : o_pix_rd_data = {{(`PIX_SHORT_W-1){1'b0}}, i_ctrl.stream_en};
				`PIX_A_ACQ       : o_pix_rd_data = {{(`PIX_SHORT_W-1){1'b0}}, i_ctrl.acq_start};
				`PIX_A_STATE     : o_pix_rd_data = i_snap.state;
				// ----------------------------------------------------------------------
				// trigger and io
				`PIX_A_TRIG_MODE : o_pix_rd_data = {{(`PIX_SHORT_W-1){1'b0}}, i_ctrl.trig_mode};
				`PIX_A_TRIG_SRC  : o_pix_rd_data = {{(`PIX_SHORT_W-4){1'b0}}, i_ctrl.trig_src};
				`PIX_A_TRIG_SOFT : o_pix_rd_data = {{(`PIX_SHORT_W-1){1'b0}}, i_ctrl.trig_soft};
				`PIX_A_TRIG_ACT  : o_pix_rd_data = {{(`PIX_SHORT_W-1){1'b0}}, i_ctrl.trig_act};
				`PIX_A_USEROUT   : o_pix_rd_data = {{(`PIX_SHORT_W-3){1'b0}}, i_ctrl.user_out};
				`PIX_A_LINE0     : o_pix_rd_data = {{(`PIX_SHORT_W-5){1'b0}}, i_ctrl.line[0]};
				`PIX_A_LINE1     : o_pix_rd_data = {{(`PIX_SHORT_W-5){1'b0}}, i_ctrl.line[1]};
				`PIX_A_LINE2     : o_pix_rd_data = {{(`PIX_SHORT_W-5){1'b0}}, i_ctrl.line[2]};
				`PIX_A_LINE3     : o_pix_rd_data = {{(`PIX_SHORT_W-5){1'b0}}, i_ctrl.line[3]};
				`PIX_A_LINE_STATUS :
					o_pix_rd_data = {{(`PIX_SHORT_W-4){1'b0}}, i_snap.line_status};
				`PIX_A_INT_EN    : o_pix_rd_data = {{(`PIX_SHORT_W-2){1'b0}}, i_ctrl.int_en};
				`PIX_A_INT_CLR   : o_pix_rd_data = {{(`PIX_SHORT_W-2){1'b0}}, i_ctrl.int_clr};
				// ----------------------------------------------------------------------
				// staged halves
				`PIX_A_FILT_RISE_H :
					o_pix_rd_data = {{(`PIX_SHORT_W-`PIX_FILT_H_W){1'b0}}, i_stage.filt_rise_h};
				`PIX_A_FILT_RISE_L : o_pix_rd_data = i_stage.filt_rise_l;
				`PIX_A_FILT_FALL_H :
					o_pix_rd_data = {{(`PIX_SHORT_W-`PIX_FILT_H_W){1'b0}}, i_stage.filt_fall_h};
				`PIX_A_FILT_FALL_L : o_pix_rd_data = i_stage.filt_fall_l;
				`PIX_A_DLY_H :
					o_pix_rd_data = {{(`PIX_SHORT_W-`PIX_DLY_H_W){1'b0}}, i_stage.dly_h};
				`PIX_A_DLY_L       : o_pix_rd_data = i_stage.dly_l;
				`PIX_A_PIXFMT_H    : o_pix_rd_data = i_stage.pixfmt_h;
				`PIX_A_PIXFMT_L    : o_pix_rd_data = i_stage.pixfmt_l;
				`PIX_A_PAYLOAD_1   : o_pix_rd_data = '0;   // upper 32 bits of payload
				`PIX_A_PAYLOAD_2   : o_pix_rd_data = '0;
				`PIX_A_PAYLOAD_3   : o_pix_rd_data = i_stage.payload_h;
				`PIX_A_PAYLOAD_4   : o_pix_rd_data = i_stage.payload_l;
				default            : o_pix_sel     = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/status_snapshot.sv */
// read-only status of the register bank
// two-flop synchronizers for the foreign-domain flags
// state word and line status frozen on each read command

`timescale 1ns/1ns
`include "pix_reg_settings.svh"
`default_nettype none

module status_snapshot (
	input  wire                        clk_pix,
	input  wire                        i_rst,
	input  wire                        i_snap_stb,
	input  pix_reg_pkg::status_in_t    i_status,
	output pix_reg_pkg::status_snap_t  o_snap
);

	logic [1:0] rst_done_sync;  // sensor reset done, osc domain
	logic [1:0] init_sync;      // ddr init done, mcb domain
	logic [1:0] err_sync;       // ddr error

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			rst_done_sync <= 2'b00;
			init_sync     <= 2'b00;
			err_sync      <= 2'b00;
		end else begin
			rst_done_sync <= {rst_done_sync[0], i_status.sensor_rst_done};
			init_sync     <= {init_sync[0], i_status.ddr_init_done};
			err_sync      <= {err_sync[0], i_status.ddr_error};
		end
	end

	// ----------------------------------------------------------------------
	// freeze on read command so a multi-word read stays consistent
	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			o_snap <= '0;
		end else if (i_snap_stb) begin
			// full frame is already a clk_pix signal
			o_snap.state <= {{(`PIX_SHORT_W-4){1'b0}}, rst_done_sync[1],
				i_status.full_frame, err_sync[1], init_sync[1]};
			o_snap.line_status <= i_status.line_status;
		end
	end

endmodule

`default_nettype wire

/* verilog/group_commit.sv */
// group commit of the two-halves registers
// filter rise and fall, trigger delay, pixel format, payload size
// all pairs load together on config done

`timescale 1ns/1ns
`include "pix_reg_settings.svh"
`default_nettype none

module group_commit (
	input  wire                      clk_pix,
	input  wire                      i_rst,
	input  wire                      i_cfg_done,     // one cycle pulse
	input  pix_reg_pkg::stage_cfg_t  i_stage,
	output pix_reg_pkg::group_cfg_t  o_group
);

	// downstream trigger and format logic only ever sees whole values
	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			o_group.filt_rise <= '0;
			o_group.filt_fall <= '0;
			o_group.delay     <= '0;
			o_group.pixfmt    <= {`PIX_RST_PIXFMT_H, `PIX_RST_PIXFMT_L};
			o_group.payload   <= {`PIX_RST_PAYLOAD_3, `PIX_RST_PAYLOAD_4};
		end else if (i_cfg_done) begin
			o_group.filt_rise <= {i_stage.filt_rise_h, i_stage.filt_rise_l};
			o_group.filt_fall <= {i_stage.filt_fall_h, i_stage.filt_fall_l};
			o_group.delay     <= {i_stage.dly_h, i_stage.dly_l};
			o_group.pixfmt    <= {i_stage.pixfmt_h, i_stage.pixfmt_l};
			o_group.payload   <= {i_stage.payload_h, i_stage.payload_l};   // 3 high, 4 low
		end
	end

endmodule

`default_nettype wire

/* verilog/ctrl_regs.sv */
// write side of the register bank
// address decode on the recovered write strobe
// read-write control registers, staging halves, self clearing pulses

`timescale 1ns/1ns
`include "pix_reg_settings.svh"
`default_nettype none

module ctrl_regs (
	input  wire                      clk_pix,
	input  wire                      i_rst,
	input  wire                      i_wr_stb,
	input  wire [`PIX_ADDR_W-1:0]    i_addr,
	input  wire [`PIX_SHORT_W-1:0]   i_wr_data,
	output pix_reg_pkg::ctrl_cfg_t   o_ctrl,
	output pix_reg_pkg::stage_cfg_t  o_stage,
	output logic                     o_cfg_done
);
	import pix_reg_pkg::*;

	line_cfg_t wr_line;     // write data as a line word

	assign wr_line    = i_wr_data[4:0];
	assign o_cfg_done = o_ctrl.cfg_done;   // drives the group commit

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			o_ctrl          <= '0;
			o_ctrl.test     <= `PIX_RST_TEST;
			o_ctrl.trig_src <= `PIX_RST_TRIG_SRC;
			o_ctrl.trig_act <= `PIX_RST_TRIG_ACT;
			o_ctrl.line[0]  <= `PIX_RST_LINE0;
			o_ctrl.line[1]  <= `PIX_RST_LINE1;
			o_ctrl.line[2]  <= `PIX_RST_LINE2;
			o_ctrl.line[3]  <= `PIX_RST_LINE3;
			o_stage           <= '0;
			o_stage.pixfmt_h  <= `PIX_RST_PIXFMT_H;
			o_stage.pixfmt_l  <= `PIX_RST_PIXFMT_L;
			o_stage.payload_h <= `PIX_RST_PAYLOAD_3;
			o_stage.payload_l <= `PIX_RST_PAYLOAD_4;
		end else begin
			// pulses drop back unless written this cycle
			o_ctrl.cfg_done  <= 1'b0;
			o_ctrl.trig_soft <= 1'b0;
			o_ctrl.int_clr   <= 2'b00;

			if (i_wr_stb) begin
				case (i_addr[`PIX_DEC_W-1:0])
					// ----------------------------------------------------------------------
					// general
					`PIX_A_TEST      : o_ctrl.test      <= i_wr_data;
					`PIX_A_CFG_DONE  : o_ctrl.cfg_done  <= i_wr_data[0];
					`PIX_A_SE        : o_ctrl.stream_en <= i_wr_data[0];
					`PIX_A_ACQ       : o_ctrl.acq_start <= i_wr_data[0];
					// ----------------------------------------------------------------------
					// trigger and io
					`PIX_A_TRIG_MODE : o_ctrl.trig_mode <= i_wr_data[0];
					`PIX_A_TRIG_SRC  : o_ctrl.trig_src  <= i_wr_data[3:0];
					`PIX_A_TRIG_SOFT : o_ctrl.trig_soft <= i_wr_data[0];
					`PIX_A_TRIG_ACT  : o_ctrl.trig_act  <= i_wr_data[0];
					`PIX_A_USEROUT   : o_ctrl.user_out  <= i_wr_data[2:0];
					`PIX_A_LINE0 : begin
						// mode bit fixed as input
						o_ctrl.line[0].source <= wr_line.source;
						o_ctrl.line[0].invert <= wr_line.invert;
					end
					`PIX_A_LINE1 : begin
						// mode bit fixed as output
						o_ctrl.line[1].source <= wr_line.source;
						o_ctrl.line[1].invert <= wr_line.invert;
					end
					`PIX_A_LINE2     : o_ctrl.line[2]   <= wr_line;
					`PIX_A_LINE3     : o_ctrl.line[3]   <= wr_line;
					`PIX_A_INT_EN    : o_ctrl.int_en    <= i_wr_data[1:0];
					`PIX_A_INT_CLR   : o_ctrl.int_clr   <= i_wr_data[1:0];
					// ----------------------------------------------------------------------
					// staging halves, take effect on config done
					`PIX_A_FILT_RISE_H : o_stage.filt_rise_h <= i_wr_data[`PIX_FILT_H_W-1:0];
					`PIX_A_FILT_RISE_L : o_stage.filt_rise_l <= i_wr_data;
					`PIX_A_FILT_FALL_H : o_stage.filt_fall_h <= i_wr_data[`PIX_FILT_H_W-1:0];
					`PIX_A_FILT_FALL_L : o_stage.filt_fall_l <= i_wr_data;
					`PIX_A_DLY_H       : o_stage.dly_h       <= i_wr_data[`PIX_DLY_H_W-1:0];
					`PIX_A_DLY_L       : o_stage.dly_l       <= i_wr_data;
					`PIX_A_PIXFMT_H    : o_stage.pixfmt_h    <= i_wr_data;
					`PIX_A_PIXFMT_L    : o_stage.pixfmt_l    <= i_wr_data;
					`PIX_A_PAYLOAD_3   : o_stage.payload_h   <= i_wr_data;
					`PIX_A_PAYLOAD_4   : o_stage.payload_l   <= i_wr_data;
					default : ;     // read-only or unmapped
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/spi_edge_sync.sv */
// serial port enable recovery on clk_pix
// three-flop shift per enable with rising edge detect

`timescale 1ns/1ns
`default_nettype none

module spi_edge_sync (
	input  wire  clk_pix,
	input  wire  i_rst,
	input  wire  i_wr_en,
	input  wire  i_cmd_is_rd,
	output logic o_wr_stb,      // single cycle
	output logic o_snap_stb     // single cycle
);

	logic [2:0] wr_shift;   // [0] is newest
	logic [2:0] rd_shift;

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			wr_shift <= 3'b000;
			rd_shift <= 3'b000;
		end else begin
			wr_shift <= {wr_shift[1:0], i_wr_en};
			rd_shift <= {rd_shift[1:0], i_cmd_is_rd};
		end
	end

	// oldest two stages 0 then 1, addr and data settled by now
	assign o_wr_stb   = (wr_shift[2:1] == 2'b01);
	assign o_snap_stb = (rd_shift[2:1] == 2'b01);

endmodule

`default_nettype wire

/* verilog/pix_reg_pkg.sv */
// register bank types
// physical line word, control and staging sets
// committed group values, raw status inputs and status snapshot

`include "pix_reg_settings.svh"
`default_nettype none

package pix_reg_pkg;

	// one physical line word, bit 0 is mode
	typedef struct packed {
		logic [2:0] source;     // 0 none, 1 strobe, 2..4 user outputs
		logic       invert;
		logic       mode;       // 1 = output
	} line_cfg_t;

	// live read-write and pulse registers
	typedef struct packed {
		logic [`PIX_SHORT_W-1:0] test;
		logic                    cfg_done;   // pulse
		logic                    stream_en;
		logic                    acq_start;
		logic                    trig_mode;
		logic [3:0]              trig_src;
		logic                    trig_soft;  // pulse
		logic                    trig_act;
		logic [2:0]              user_out;
		line_cfg_t [3:0]         line;
		logic [1:0]              int_en;
		logic [1:0]              int_clr;    // pulse
	} ctrl_cfg_t;

	// halves as written, not yet in effect
	typedef struct packed {
		logic [`PIX_FILT_H_W-1:0] filt_rise_h;
		logic [`PIX_SHORT_W-1:0]  filt_rise_l;
		logic [`PIX_FILT_H_W-1:0] filt_fall_h;
		logic [`PIX_SHORT_W-1:0]  filt_fall_l;
		logic [`PIX_DLY_H_W-1:0]  dly_h;
		logic [`PIX_SHORT_W-1:0]  dly_l;
		logic [`PIX_SHORT_W-1:0]  pixfmt_h;
		logic [`PIX_SHORT_W-1:0]  pixfmt_l;
		logic [`PIX_SHORT_W-1:0]  payload_h;  // payload 3
		logic [`PIX_SHORT_W-1:0]  payload_l;  // payload 4
	} stage_cfg_t;

	// joined values after config done
	typedef struct packed {
		logic [`PIX_TRIG_FILTER_W-1:0] filt_rise;
		logic [`PIX_TRIG_FILTER_W-1:0] filt_fall;
		logic [`PIX_TRIG_DELAY_W-1:0]  delay;
		logic [`PIX_LONG_W-1:0]        pixfmt;
		logic [`PIX_LONG_W-1:0]        payload;
	} group_cfg_t;

	// status from other clock domains
	typedef struct packed {
		logic       sensor_rst_done;
		logic       ddr_init_done;
		logic       ddr_error;
		logic       full_frame;     // already on clk_pix
		logic [3:0] line_status;
	} status_in_t;

	typedef struct packed {
		logic [`PIX_SHORT_W-1:0] state;
		logic [3:0]              line_status;
	} status_snap_t;

endpackage

`default_nettype wire

/* verilog/pix_reg_settings.svh */
// register bank settings
// bus and register widths
// decoded register map of the pixel-clock bank
// reset values of the control and staging registers

`ifndef PIX_REG_SETTINGS_SVH
`define PIX_REG_SETTINGS_SVH
`default_nettype none

// ----------------------------------------------------------------------
// widths
`define PIX_ADDR_W          16      // serial port address
`define PIX_DEC_W           9       // only addr[8:0] is decoded
`define PIX_SHORT_W         16      // one register word
`define PIX_LONG_W          32      // joined two-halves value
`define PIX_TRIG_FILTER_W   19
`define PIX_TRIG_DELAY_W    28
// high halves carry only what is left above the low word
`define PIX_FILT_H_W        (`PIX_TRIG_FILTER_W-`PIX_SHORT_W)
`define PIX_DLY_H_W         (`PIX_TRIG_DELAY_W-`PIX_SHORT_W)

// ----------------------------------------------------------------------
// register map
`define PIX_A_TEST          9'h010
`define PIX_A_CFG_DONE      9'h020  // self clearing
`define PIX_A_SE            9'h030
`define PIX_A_STATE         9'h031  // read only
`define PIX_A_ACQ           9'h032
`define PIX_A_PIXFMT_H      9'h033
`define PIX_A_PIXFMT_L      9'h034
`define PIX_A_PAYLOAD_1     9'h035  // always reads zero
`define PIX_A_PAYLOAD_2     9'h036  // always reads zero
`define PIX_A_PAYLOAD_3     9'h037
`define PIX_A_PAYLOAD_4     9'h038
`define PIX_A_TRIG_MODE     9'h050
`define PIX_A_TRIG_SRC      9'h051
`define PIX_A_TRIG_SOFT     9'h052  // self clearing
`define PIX_A_TRIG_ACT      9'h053
`define PIX_A_FILT_RISE_H   9'h054
`define PIX_A_FILT_RISE_L   9'h055
`define PIX_A_FILT_FALL_H   9'h056
`define PIX_A_FILT_FALL_L   9'h057
`define PIX_A_DLY_H         9'h060
`define PIX_A_DLY_L         9'h061
`define PIX_A_USEROUT       9'h062
`define PIX_A_LINE0         9'h063
`define PIX_A_LINE1         9'h064
`define PIX_A_LINE2         9'h065
`define PIX_A_LINE3         9'h066
`define PIX_A_LINE_STATUS   9'h067  // read only
`define PIX_A_INT_EN        9'h080
`define PIX_A_INT_CLR       9'h083  // self clearing

// ----------------------------------------------------------------------
// reset values, everything not listed resets to 0
`define PIX_RST_TEST        16'h55aa
`define PIX_RST_TRIG_SRC    4'h1    // line0 as default source
`define PIX_RST_TRIG_ACT    1'b1    // rising edge active
`define PIX_RST_LINE0       5'h00   // input
`define PIX_RST_LINE1       5'h09   // output, user output0
`define PIX_RST_LINE2       5'h08
`define PIX_RST_LINE3       5'h08
`define PIX_RST_PIXFMT_H    16'h0108
`define PIX_RST_PIXFMT_L    16'h0001
`define PIX_RST_PAYLOAD_3   16'h004c
`define PIX_RST_PAYLOAD_4   16'he300

`default_nettype wire
`endif
